//--- source/io_pkg.sv
// I/O subsystem package
// address, data width, I/O window and register bank constants shared by the
// bridge, the decoder, the register banks and the testbench
package io_pkg;

	// ====================
	// bus widths
	// ====================

	// byte address width on every bus of the subsystem
	localparam int ADR_W = 32;

	// wide data bus and its byte selects
	localparam int DAT_W = 64;
	localparam int SEL_W = 8;

	// lane bus carries one 32-bit half of the wide bus
	localparam int DAT32_W = 32;
	localparam int SEL32_W = 4;

	// ====================
	// I/O window
	// ====================

	// the top address bits must equal IO_BASE for the bridge to take a request
	localparam int IO_BASE_W = 12;
	localparam logic [IO_BASE_W-1:0] IO_BASE = 12'hFFD;

	// device field inside the window, one 4 KB page per device
	localparam int DEV_MSB = 19;
	localparam int DEV_LSB = 12;
	localparam logic [DEV_MSB-DEV_LSB:0] DEV_REG64 = 8'd0;
	localparam logic [DEV_MSB-DEV_LSB:0] DEV_REG32 = 8'd1;

	// words held by each register bank
	localparam int BANK_DEPTH = 16;

endpackage

//--- source/io_bridge.sv
// two-port I/O bridge
// filters both requesters against the I/O window, arbitrates with port 1 first,
// and registers the winning request onto the 64-bit bus and the 32-bit lane bus
`timescale 1ns/1ps

module io_bridge (
	input  logic                        clk_i,
	input  logic                        rst_i,
	// port 1, the CPU data port
	input  logic                        s1_cyc_i,
	input  logic                        s1_stb_i,
	input  logic                        s1_we_i,
	input  logic [io_pkg::SEL_W-1:0]    s1_sel_i,
	input  logic [io_pkg::ADR_W-1:0]    s1_adr_i,
	input  logic [io_pkg::DAT_W-1:0]    s1_dat_i,
	output logic                        s1_ack_o,
	output logic [io_pkg::DAT_W-1:0]    s1_dat_o,
	// port 2, the second master
	input  logic                        s2_cyc_i,
	input  logic                        s2_stb_i,
	input  logic                        s2_we_i,
	input  logic [io_pkg::SEL_W-1:0]    s2_sel_i,
	input  logic [io_pkg::ADR_W-1:0]    s2_adr_i,
	input  logic [io_pkg::DAT_W-1:0]    s2_dat_i,
	output logic                        s2_ack_o,
	output logic [io_pkg::DAT_W-1:0]    s2_dat_o,
	// registered I/O bus
	output logic                        m_cyc_o,
	output logic                        m_stb_o,
	output logic                        m_we_o,
	output logic [io_pkg::SEL_W-1:0]    m_sel_o,
	output logic [io_pkg::ADR_W-1:0]    m_adr_o,
	output logic [io_pkg::DAT_W-1:0]    m_dat_o,
	output logic [io_pkg::SEL32_W-1:0]  m_sel32_o,
	output logic [io_pkg::ADR_W-1:0]    m_adr32_o,
	output logic [io_pkg::DAT32_W-1:0]  m_dat32_o,
	input  logic                        m_ack_i,
	input  logic [io_pkg::DAT_W-1:0]    m_dat_i
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_WAIT_ACK,
		ST_WAIT_NACK
	} state_t;

	state_t                       state_q;
	// low when port 1 owns the outstanding cycle, high for port 2
	logic                         which_q;

	logic                         s1_hit;
	logic                         s2_hit;
	logic                         req_we;
	logic [io_pkg::SEL_W-1:0]     req_sel;
	logic [io_pkg::ADR_W-1:0]     req_adr;
	logic [io_pkg::DAT_W-1:0]     req_dat;
	logic                         req_upper;
	logic                         win_cyc;
	logic                         win_stb;

	// ====================
	// filter and arbitrate
	// ====================

	// a port only counts as requesting when its address falls in the I/O window
	assign s1_hit = s1_cyc_i &&
		(s1_adr_i[io_pkg::ADR_W-1 -: io_pkg::IO_BASE_W] == io_pkg::IO_BASE);
	assign s2_hit = s2_cyc_i &&
		(s2_adr_i[io_pkg::ADR_W-1 -: io_pkg::IO_BASE_W] == io_pkg::IO_BASE);

	// port 1 takes the bus whenever both ports hit in the same cycle
	assign req_we  = s1_hit ? s1_we_i  : s2_we_i;
	assign req_sel = s1_hit ? s1_sel_i : s2_sel_i;
	assign req_adr = s1_hit ? s1_adr_i : s2_adr_i;
	assign req_dat = s1_hit ? s1_dat_i : s2_dat_i;

	// any byte in the upper half steers the lane bus to the odd 32-bit word
	assign req_upper = |req_sel[io_pkg::SEL_W-1:io_pkg::SEL32_W];

	// strobes of whichever port owns the current cycle
	assign win_cyc = which_q ? s2_cyc_i : s1_cyc_i;
	assign win_stb = which_q ? s2_stb_i : s1_stb_i;

	// ====================
	// control FSM
	// ====================

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state_q  <= ST_IDLE;
			which_q  <= 1'b0;
			m_cyc_o  <= 1'b0;
			m_stb_o  <= 1'b0;
			s1_ack_o <= 1'b0;
			s2_ack_o <= 1'b0;
		end else begin
			case (state_q)
				ST_IDLE: begin
					if (s1_hit || s2_hit) begin
						which_q <= !s1_hit;
						m_cyc_o <= 1'b1;
						m_stb_o <= 1'b1;
						state_q <= ST_WAIT_ACK;
					end
				end
				ST_WAIT_ACK: begin
					// an abort wins over a late ack so no ack reaches an idle port
					if (!win_cyc) begin
						m_cyc_o <= 1'b0;
						m_stb_o <= 1'b0;
						state_q <= ST_IDLE;
					end else if (m_ack_i) begin
						m_cyc_o  <= 1'b0;
						m_stb_o  <= 1'b0;
						s1_ack_o <= !which_q;
						s2_ack_o <= which_q;
						state_q  <= ST_WAIT_NACK;
					end
				end
				ST_WAIT_NACK: begin
					// hold the ack until the owning port lets go of stb
					if (!win_stb) begin
						s1_ack_o <= 1'b0;
						s2_ack_o <= 1'b0;
						state_q  <= ST_IDLE;
					end
				end
				default: begin
					state_q <= ST_IDLE;
				end
			endcase
		end
	end

	// ====================
	// request and return data
	// ====================

	always_ff @(posedge clk_i) begin
		if (state_q == ST_IDLE && (s1_hit || s2_hit)) begin
			m_we_o  <= req_we;
			m_sel_o <= req_sel;
			// upper bits are forced so devices can skip comparing them
			m_adr_o <= {io_pkg::IO_BASE, req_adr[io_pkg::ADR_W-io_pkg::IO_BASE_W-1:0]};
			m_dat_o <= req_dat;
			// lane form of the same request, bit 2 picks the half and bits 1:0 are zero
			m_sel32_o <= req_sel[io_pkg::SEL_W-1:io_pkg::SEL32_W] |
				req_sel[io_pkg::SEL32_W-1:0];
			m_adr32_o <= {io_pkg::IO_BASE, req_adr[io_pkg::ADR_W-io_pkg::IO_BASE_W-1:3],
				req_upper, 2'b00};
			m_dat32_o <= req_upper ? req_dat[io_pkg::DAT_W-1:io_pkg::DAT32_W] :
				req_dat[io_pkg::DAT32_W-1:0];
		end
	end

	// read data is captured only for the port that owns the cycle
	always_ff @(posedge clk_i) begin
		if (state_q == ST_WAIT_ACK && win_cyc && m_ack_i) begin
			if (which_q) begin
				s2_dat_o <= m_dat_i;
			end else begin
				s1_dat_o <= m_dat_i;
			end
		end
	end

endmodule

//--- source/io_decoder.sv
// I/O window decoder
// selects a register bank from the device field of the registered bus, returns
// its ack and read data, and answers unclaimed devices with zero data
`timescale 1ns/1ps

module io_decoder (
	// registered bus from the bridge
	input  logic                        m_cyc_i,
	input  logic                        m_stb_i,
	input  logic                        m_we_i,
	input  logic [io_pkg::SEL_W-1:0]    m_sel_i,
	input  logic [io_pkg::ADR_W-1:0]    m_adr_i,
	input  logic [io_pkg::DAT_W-1:0]    m_dat_i,
	input  logic [io_pkg::SEL32_W-1:0]  m_sel32_i,
	input  logic [io_pkg::ADR_W-1:0]    m_adr32_i,
	input  logic [io_pkg::DAT32_W-1:0]  m_dat32_i,
	output logic                        m_ack_o,
	output logic [io_pkg::DAT_W-1:0]    m_dat_o,
	// 64-bit bank
	output logic                        r64_stb_o,
	output logic                        r64_we_o,
	output logic [io_pkg::SEL_W-1:0]    r64_sel_o,
	output logic [io_pkg::ADR_W-1:0]    r64_adr_o,
	output logic [io_pkg::DAT_W-1:0]    r64_dat_o,
	input  logic                        r64_ack_i,
	input  logic [io_pkg::DAT_W-1:0]    r64_dat_i,
	// 32-bit bank on the lane bus
	output logic                        r32_stb_o,
	output logic                        r32_we_o,
	output logic [io_pkg::SEL32_W-1:0]  r32_sel_o,
	output logic [io_pkg::ADR_W-1:0]    r32_adr_o,
	output logic [io_pkg::DAT32_W-1:0]  r32_dat_o,
	input  logic                        r32_ack_i,
	input  logic [io_pkg::DAT32_W-1:0]  r32_dat_i
);

	logic [io_pkg::DEV_MSB-io_pkg::DEV_LSB:0] dev;
	logic                                     hit64;
	logic                                     hit32;

	assign dev   = m_adr_i[io_pkg::DEV_MSB:io_pkg::DEV_LSB];
	assign hit64 = (dev == io_pkg::DEV_REG64);
	assign hit32 = (dev == io_pkg::DEV_REG32);

	// the wide bank sees the wide bus as it is
	assign r64_stb_o = m_cyc_i && m_stb_i && hit64;
	assign r64_we_o  = m_we_i;
	assign r64_sel_o = m_sel_i;
	assign r64_adr_o = m_adr_i;
	assign r64_dat_o = m_dat_i;

	// the narrow bank takes the lane form prepared by the bridge
	assign r32_stb_o = m_cyc_i && m_stb_i && hit32;
	assign r32_we_o  = m_we_i;
	assign r32_sel_o = m_sel32_i;
	assign r32_adr_o = m_adr32_i;
	assign r32_dat_o = m_dat32_i;

	// return path, a hole acks at once so the requester never hangs on it
	always_comb begin
		if (hit64) begin
			m_ack_o = r64_ack_i;
			m_dat_o = r64_dat_i;
		end else if (hit32) begin
			m_ack_o = r32_ack_i;
			// the narrow word shows up in both halves so either lane reads it
			m_dat_o = {r32_dat_i, r32_dat_i};
		end else begin
			// anything else in the window belongs to nobody
			m_ack_o = m_cyc_i && m_stb_i;
			m_dat_o = '0;
		end
	end

endmodule

//--- source/io_reg_bank.sv
// byte-writable register bank device
// a small register file with one wait state, sized by the word type it holds
`timescale 1ns/1ps

module io_reg_bank #(
	parameter type word_t = logic [io_pkg::DAT_W-1:0]
) (
	input  logic                      clk_i,
	input  logic                      rst_i,
	input  logic                      stb_i,
	input  logic                      we_i,
	input  logic [$bits(word_t)/8-1:0] sel_i,
	input  logic [io_pkg::ADR_W-1:0]  adr_i,
	input  word_t                     dat_i,
	output logic                      ack_o,
	output word_t                     dat_o
);

	// ====================
	// geometry
	// ====================

	// byte lanes in one word
	localparam int SEL_N   = $bits(word_t) / 8;
	// lowest address bit that picks a word
	localparam int ADR_LSB = $clog2(SEL_N);
	// bits needed to index BANK_DEPTH words
	localparam int IDX_W   = $clog2(io_pkg::BANK_DEPTH);

	word_t              mem [io_pkg::BANK_DEPTH];
	logic [IDX_W-1:0]   idx;
	logic               wait_q;

	assign idx = adr_i[ADR_LSB +: IDX_W];

	// ====================
	// handshake
	// ====================

	// stb rises, one wait cycle passes, then ack rises and is held while stb stays high
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			wait_q <= 1'b0;
			ack_o  <= 1'b0;
		end else if (!stb_i) begin
			wait_q <= 1'b0;
			ack_o  <= 1'b0;
		end else if (!wait_q && !ack_o) begin
			wait_q <= 1'b1;
		end else if (wait_q) begin
			wait_q <= 1'b0;
			ack_o  <= 1'b1;
		end
	end

	// ====================
	// storage
	// ====================

	// the write lands on the same edge that raises ack
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			for (int w = 0; w < io_pkg::BANK_DEPTH; w++) begin
				mem[w] <= '0;
			end
		end else if (stb_i && we_i && wait_q) begin
			for (int b = 0; b < SEL_N; b++) begin
				if (sel_i[b]) begin
					mem[idx][b*8 +: 8] <= dat_i[b*8 +: 8];
				end
			end
		end
	end

	// read data is only valid while ack is up
	assign dat_o = ack_o ? mem[idx] : '0;

endmodule

//--- source/io_subsystem.sv
// I/O bridge subsystem top level
// two requesters reach a 64-bit and a 32-bit register bank through the bridge
// and the window decoder
`timescale 1ns/1ps

module io_subsystem (
	input  logic                      clk_i,
	input  logic                      rst_i,
	input  logic                      s1_cyc_i,
	input  logic                      s1_stb_i,
	input  logic                      s1_we_i,
	input  logic [io_pkg::SEL_W-1:0]  s1_sel_i,
	input  logic [io_pkg::ADR_W-1:0]  s1_adr_i,
	input  logic [io_pkg::DAT_W-1:0]  s1_dat_i,
	output logic                      s1_ack_o,
	output logic [io_pkg::DAT_W-1:0]  s1_dat_o,
	input  logic                      s2_cyc_i,
	input  logic                      s2_stb_i,
	input  logic                      s2_we_i,
	input  logic [io_pkg::SEL_W-1:0]  s2_sel_i,
	input  logic [io_pkg::ADR_W-1:0]  s2_adr_i,
	input  logic [io_pkg::DAT_W-1:0]  s2_dat_i,
	output logic                      s2_ack_o,
	output logic [io_pkg::DAT_W-1:0]  s2_dat_o
);

	// ====================
	// registered I/O bus
	// ====================

	logic                        io_cyc;
	logic                        io_stb;
	logic                        io_we;
	logic [io_pkg::SEL_W-1:0]    io_sel;
	logic [io_pkg::ADR_W-1:0]    io_adr;
	logic [io_pkg::DAT_W-1:0]    io_dat_w;
	logic [io_pkg::SEL32_W-1:0]  io_sel32;
	logic [io_pkg::ADR_W-1:0]    io_adr32;
	logic [io_pkg::DAT32_W-1:0]  io_dat32_w;
	logic                        io_ack;
	logic [io_pkg::DAT_W-1:0]    io_dat_r;

	// ====================
	// bank links
	// ====================

	logic                        r64_stb;
	logic                        r64_we;
	logic [io_pkg::SEL_W-1:0]    r64_sel;
	logic [io_pkg::ADR_W-1:0]    r64_adr;
	logic [io_pkg::DAT_W-1:0]    r64_dat_w;
	logic                        r64_ack;
	logic [io_pkg::DAT_W-1:0]    r64_dat_r;
	logic                        r32_stb;
	logic                        r32_we;
	logic [io_pkg::SEL32_W-1:0]  r32_sel;
	logic [io_pkg::ADR_W-1:0]    r32_adr;
	logic [io_pkg::DAT32_W-1:0]  r32_dat_w;
	logic                        r32_ack;
	logic [io_pkg::DAT32_W-1:0]  r32_dat_r;

	io_bridge i_io_bridge (
		.clk_i     (clk_i),
		.rst_i     (rst_i),
		.s1_cyc_i  (s1_cyc_i),
		.s1_stb_i  (s1_stb_i),
		.s1_we_i   (s1_we_i),
		.s1_sel_i  (s1_sel_i),
		.s1_adr_i  (s1_adr_i),
		.s1_dat_i  (s1_dat_i),
		.s1_ack_o  (s1_ack_o),
		.s1_dat_o  (s1_dat_o),
		.s2_cyc_i  (s2_cyc_i),
		.s2_stb_i  (s2_stb_i),
		.s2_we_i   (s2_we_i),
		.s2_sel_i  (s2_sel_i),
		.s2_adr_i  (s2_adr_i),
		.s2_dat_i  (s2_dat_i),
		.s2_ack_o  (s2_ack_o),
		.s2_dat_o  (s2_dat_o),
		.m_cyc_o   (io_cyc),
		.m_stb_o   (io_stb),
		.m_we_o    (io_we),
		.m_sel_o   (io_sel),
		.m_adr_o   (io_adr),
		.m_dat_o   (io_dat_w),
		.m_sel32_o (io_sel32),
		.m_adr32_o (io_adr32),
		.m_dat32_o (io_dat32_w),
		.m_ack_i   (io_ack),
		.m_dat_i   (io_dat_r)
	);

	io_decoder i_io_decoder (
		.m_cyc_i   (io_cyc),
		.m_stb_i   (io_stb),
		.m_we_i    (io_we),
		.m_sel_i   (io_sel),
		.m_adr_i   (io_adr),
		.m_dat_i   (io_dat_w),
		.m_sel32_i (io_sel32),
		.m_adr32_i (io_adr32),
		.m_dat32_i (io_dat32_w),
		.m_ack_o   (io_ack),
		.m_dat_o   (io_dat_r),
		.r64_stb_o (r64_stb),
		.r64_we_o  (r64_we),
		.r64_sel_o (r64_sel),
		.r64_adr_o (r64_adr),
		.r64_dat_o (r64_dat_w),
		.r64_ack_i (r64_ack),
		.r64_dat_i (r64_dat_r),
		.r32_stb_o (r32_stb),
		.r32_we_o  (r32_we),
		.r32_sel_o (r32_sel),
		.r32_adr_o (r32_adr),
		.r32_dat_o (r32_dat_w),
		.r32_ack_i (r32_ack),
		.r32_dat_i (r32_dat_r)
	);

	// wide bank on the 64-bit bus
	io_reg_bank #(
		.word_t (logic [io_pkg::DAT_W-1:0])
	) i_reg64 (
		.clk_i (clk_i),
		.rst_i (rst_i),
		.stb_i (r64_stb),
		.we_i  (r64_we),
		.sel_i (r64_sel),
		.adr_i (r64_adr),
		.dat_i (r64_dat_w),
		.ack_o (r64_ack),
		.dat_o (r64_dat_r)
	);

	// narrow bank on the lane bus
	io_reg_bank #(
		.word_t (logic [io_pkg::DAT32_W-1:0])
	) i_reg32 (
		.clk_i (clk_i),
		.rst_i (rst_i),
		.stb_i (r32_stb),
		.we_i  (r32_we),
		.sel_i (r32_sel),
		.adr_i (r32_adr),
		.dat_i (r32_dat_w),
		.ack_o (r32_ack),
		.dat_o (r32_dat_r)
	);

endmodule

//--- sim/tb_clock.sv
// testbench clock generator
// free-running clock with a 40 ns period
`timescale 1ns/1ps

module tb_clock (
	output logic clk_o
);

	localparam int HALF_PERIOD = 20;

	initial begin
		clk_o = 1'b0;
		forever begin
			#HALF_PERIOD clk_o = ~clk_o;
		end
	end

endmodule

//--- sim/io_bridge_chk.sv
// bridge protocol checker
// concurrent assertions on the port acks and the registered bus cycle,
// bound into the bridge from the testbench
`timescale 1ns/1ps

module io_bridge_chk (
	input logic clk_i,
	input logic rst_i,
	input logic s1_cyc_i,
	input logic s1_stb_i,
	input logic s1_ack_i,
	input logic s2_cyc_i,
	input logic s2_stb_i,
	input logic s2_ack_i,
	input logic m_cyc_i,
	input logic m_ack_i,
	input logic which_i
);

	// high once a reset has been sampled at a clock edge
	logic reset_seen = 1'b0;
	// high from the first request after reset
	logic req_seen;
	// cyc of the port that owns the outstanding cycle
	logic win_cyc;
	// number of assertion failures so far
	int   fail_cnt = 0;

	assign win_cyc = which_i ? s2_cyc_i : s1_cyc_i;

	always @(posedge clk_i) begin
		if (rst_i) begin
			reset_seen <= 1'b1;
			req_seen   <= 1'b0;
		end else if (s1_cyc_i || s2_cyc_i) begin
			req_seen <= 1'b1;
		end
	end

	// ====================
	// protocol rules
	// ====================

	// only one requester is ever answered at a time
	a_one_ack: assert property (@(posedge clk_i) disable iff (rst_i)
		!(s1_ack_i && s2_ack_i))
		else begin
			fail_cnt++;
			$error("both port acks are high in the same cycle");
		end

	// an ack only answers a strobe that was up on the edge that raised it
	a_s1_ack_stb: assert property (@(posedge clk_i) disable iff (rst_i)
		$rose(s1_ack_i) |-> $past(s1_stb_i))
		else begin
			fail_cnt++;
			$error("port 1 ack rose while port 1 stb was low");
		end

	a_s2_ack_stb: assert property (@(posedge clk_i) disable iff (rst_i)
		$rose(s2_ack_i) |-> $past(s2_stb_i))
		else begin
			fail_cnt++;
			$error("port 2 ack rose while port 2 stb was low");
		end

	// the subsystem stays quiet from reset until somebody asks
	a_quiet: assert property (@(posedge clk_i)
		reset_seen && !req_seen |-> !s1_ack_i && !s2_ack_i && !m_cyc_i)
		else begin
			fail_cnt++;
			$error("an ack or the bus cycle came up before any request");
		end

	// the bus cycle only ends on a device ack or an abort by the owner
	a_cyc_hold: assert property (@(posedge clk_i) disable iff (rst_i)
		m_cyc_i && !m_ack_i && win_cyc |=> m_cyc_i)
		else begin
			fail_cnt++;
			$error("bus cycle dropped without an ack or an abort");
		end

endmodule

//--- sim/io_subsystem_tb.sv
// testbench for the I/O bridge subsystem
// runs both requesters through the window, checks reads against a reference
// memory model and binds the bridge protocol checker
`timescale 1ns/1ps

module io_subsystem_tb;

	localparam int DRIVE_DLY    = 2;
	localparam int RESET_CYCLES = 8;
	localparam int ACK_LIMIT    = 50;
	localparam int MISS_LIMIT   = 20;
	localparam int HOLE_DEV     = 5;

	logic                              clk;
	logic                              rst;
	// index 1 is port 1, index 2 is port 2
	logic [2:1]                        cyc;
	logic [2:1]                        stb;
	logic [2:1]                        we;
	logic [2:1][io_pkg::SEL_W-1:0]     sel;
	logic [2:1][io_pkg::ADR_W-1:0]     adr;
	logic [2:1][io_pkg::DAT_W-1:0]     wdat;
	logic [2:1]                        ack;
	logic [2:1][io_pkg::DAT_W-1:0]     rdat;

	// reference contents of both banks
	logic [io_pkg::DAT_W-1:0]          mem64 [io_pkg::BANK_DEPTH];
	logic [io_pkg::DAT32_W-1:0]        mem32 [io_pkg::BANK_DEPTH];

	int                                seed;
	int unsigned                       cycle_cnt = 0;
	int                                checks;
	int                                data_errors;
	int                                bus_errors;
	int                                assert_errors;

	tb_clock i_tb_clock (
		.clk_o (clk)
	);

	io_subsystem i_io_subsystem (
		.clk_i    (clk),
		.rst_i    (rst),
		.s1_cyc_i (cyc[1]),
		.s1_stb_i (stb[1]),
		.s1_we_i  (we[1]),
		.s1_sel_i (sel[1]),
		.s1_adr_i (adr[1]),
		.s1_dat_i (wdat[1]),
		.s1_ack_o (ack[1]),
		.s1_dat_o (rdat[1]),
		.s2_cyc_i (cyc[2]),
		.s2_stb_i (stb[2]),
		.s2_we_i  (we[2]),
		.s2_sel_i (sel[2]),
		.s2_adr_i (adr[2]),
		.s2_dat_i (wdat[2]),
		.s2_ack_o (ack[2]),
		.s2_dat_o (rdat[2])
	);

	bind io_bridge io_bridge_chk i_io_bridge_chk (
		.clk_i    (clk_i),
		.rst_i    (rst_i),
		.s1_cyc_i (s1_cyc_i),
		.s1_stb_i (s1_stb_i),
		.s1_ack_i (s1_ack_o),
		.s2_cyc_i (s2_cyc_i),
		.s2_stb_i (s2_stb_i),
		.s2_ack_i (s2_ack_o),
		.m_cyc_i  (m_cyc_o),
		.m_ack_i  (m_ack_i),
		.which_i  (which_q)
	);

	// counts edges so the order of acks can be compared
	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
	end

	// ====================
	// address and data helpers
	// ====================

	function automatic logic [io_pkg::ADR_W-1:0] io_addr(
		input logic [io_pkg::DEV_MSB-io_pkg::DEV_LSB:0] dev,
		input logic [io_pkg::DEV_LSB-1:0]               offset
	);
		logic [io_pkg::ADR_W-1:0] a;
		a = '0;
		a[io_pkg::ADR_W-1 -: io_pkg::IO_BASE_W] = io_pkg::IO_BASE;
		a[io_pkg::DEV_MSB:io_pkg::DEV_LSB] = dev;
		a[io_pkg::DEV_LSB-1:0] = offset;
		return a;
	endfunction

	// byte offset of a word in the 64-bit bank
	function automatic logic [11:0] off64(input logic [3:0] idx);
		return {5'h0, idx, 3'h0};
	endfunction

	// byte offset of the 64-bit slot that holds a 32-bit bank word pair
	function automatic logic [11:0] off32(input logic [3:0] k);
		return {6'h0, k[3:1], 3'h0};
	endfunction

	function automatic logic [io_pkg::DAT_W-1:0] merge_bytes(
		input logic [io_pkg::DAT_W-1:0] old_d,
		input logic [io_pkg::DAT_W-1:0] new_d,
		input logic [io_pkg::SEL_W-1:0] s
	);
		logic [io_pkg::DAT_W-1:0] r;
		r = old_d;
		for (int b = 0; b < io_pkg::SEL_W; b++) begin
			if (s[b]) begin
				r[b*8 +: 8] = new_d[b*8 +: 8];
			end
		end
		return r;
	endfunction

	function automatic logic [io_pkg::DAT_W-1:0] rand_word();
		return {$random(seed), $random(seed)};
	endfunction

	function automatic void compare_data(
		input string                    name,
		input logic [io_pkg::DAT_W-1:0] expected,
		input logic [io_pkg::DAT_W-1:0] actual
	);
		checks++;
		assert (actual === expected) else begin
			data_errors++;
			$display("FAILED %s: expected %h, actual %h", name, expected, actual);
		end
	endfunction

	function automatic void check_idle(input string phase);
		checks++;
		assert (ack === 2'b00) else begin
			bus_errors++;
			$display("ERROR: a port ack is high %s before any request", phase);
		end
	endfunction

	// ====================
	// bus tasks
	// ====================

	// runs one cycle on a port, entered and left 2 ns after a rising edge
	task automatic bus_cycle(
		input  int                       port,
		input  logic                     write,
		input  logic [io_pkg::SEL_W-1:0] s,
		input  logic [io_pkg::ADR_W-1:0] a,
		input  logic [io_pkg::DAT_W-1:0] d,
		input  bit                       expect_ack,
		output logic [io_pkg::DAT_W-1:0] q,
		output int unsigned              ack_cycle
	);
		int waited;
		int limit;
		bit got_ack;
		limit = expect_ack ? ACK_LIMIT : MISS_LIMIT;
		waited = 0;
		got_ack = 1'b0;
		q = '0;
		ack_cycle = 0;
		cyc[port] = 1'b1;
		stb[port] = 1'b1;
		we[port] = write;
		sel[port] = s;
		adr[port] = a;
		wdat[port] = d;
		while (!got_ack && waited < limit) begin
			@(posedge clk);
			#DRIVE_DLY;
			waited++;
			if (ack[port]) begin
				got_ack = 1'b1;
				q = rdat[port];
				ack_cycle = cycle_cnt;
			end
		end
		stb[port] = 1'b0;
		cyc[port] = 1'b0;
		we[port] = 1'b0;
		checks++;
		assert (got_ack == expect_ack) else begin
			bus_errors++;
			if (expect_ack) begin
				$display("ERROR: port %0d got no ack for address %h within %0d cycles",
					port, a, limit);
			end else begin
				$display("ERROR: port %0d was acked for address %h outside the window",
					port, a);
			end
		end
		// the bridge clears its ack on the edge after stb falls
		@(posedge clk);
		#DRIVE_DLY;
	endtask

	task automatic write64(
		input int                       port,
		input logic [3:0]               idx,
		input logic [io_pkg::SEL_W-1:0] s,
		input logic [io_pkg::DAT_W-1:0] d
	);
		logic [io_pkg::DAT_W-1:0] q;
		int unsigned              t;
		bus_cycle(port, 1'b1, s, io_addr(io_pkg::DEV_REG64, off64(idx)), d, 1'b1, q, t);
		mem64[idx] = merge_bytes(mem64[idx], d, s);
	endtask

	task automatic write32(
		input int                       port,
		input logic [3:0]               k,
		input logic [io_pkg::SEL_W-1:0] s,
		input logic [io_pkg::DAT_W-1:0] d
	);
		logic [io_pkg::DAT_W-1:0]   q;
		int unsigned                t;
		logic                       upper;
		logic [3:0]                 lane_sel;
		logic [io_pkg::DAT32_W-1:0] lane_dat;
		logic [3:0]                 lane_idx;
		logic [io_pkg::DAT_W-1:0]   merged;
		bus_cycle(port, 1'b1, s, io_addr(io_pkg::DEV_REG32, off32(k)), d, 1'b1, q, t);
		// any selected upper byte steers the write to the odd word and the upper half
		upper = |s[7:4];
		lane_sel = s[7:4] | s[3:0];
		lane_dat = upper ? d[63:32] : d[31:0];
		lane_idx = {k[3:1], upper};
		merged = merge_bytes({32'h0, mem32[lane_idx]}, {32'h0, lane_dat}, {4'h0, lane_sel});
		mem32[lane_idx] = merged[31:0];
	endtask

	task automatic read_check(
		input string                    name,
		input int                       port,
		input logic [io_pkg::SEL_W-1:0] s,
		input logic [io_pkg::ADR_W-1:0] a,
		input logic [io_pkg::DAT_W-1:0] expected
	);
		logic [io_pkg::DAT_W-1:0] q;
		int unsigned              t;
		bus_cycle(port, 1'b0, s, a, '0, 1'b1, q, t);
		compare_data(name, expected, q);
	endtask

	// reads every word of both banks back through port 1
	task automatic verify_banks(input string name);
		logic [3:0] k;
		for (int i = 0; i < io_pkg::BANK_DEPTH; i++) begin
			k = i[3:0];
			read_check(name, 1, 8'hFF, io_addr(io_pkg::DEV_REG64, off64(k)), mem64[k]);
			read_check(name, 1, k[0] ? 8'hF0 : 8'h0F,
				io_addr(io_pkg::DEV_REG32, off32(k)), {mem32[k], mem32[k]});
		end
	endtask

	// ====================
	// stimulus
	// ====================

	initial begin
		logic [31:0]              rnd;
		logic [3:0]               k;
		logic [3:0]               nib;
		logic [io_pkg::DAT_W-1:0] q1;
		logic [io_pkg::DAT_W-1:0] q2;
		logic [io_pkg::DAT_W-1:0] d1;
		logic [io_pkg::DAT_W-1:0] d2;
		int unsigned              t1;
		int unsigned              t2;
		seed = 48;
		rst = 1'b1;
		cyc = '0;
		stb = '0;
		we = '0;
		sel = '0;
		adr = '0;
		wdat = '0;
		checks = 0;
		data_errors = 0;
		bus_errors = 0;
		assert_errors = 0;
		for (int i = 0; i < io_pkg::BANK_DEPTH; i++) begin
			mem64[i] = '0;
			mem32[i] = '0;
		end

		// both acks stay low through reset and while nobody requests
		for (int i = 0; i < RESET_CYCLES; i++) begin
			@(posedge clk);
			#DRIVE_DLY;
			check_idle("during reset");
		end
		rst = 1'b0;
		for (int i = 0; i < 4; i++) begin
			@(posedge clk);
			#DRIVE_DLY;
			check_idle("after reset");
		end

		// 64-bit bank, two random passes so later writes merge into earlier ones
		for (int pass = 0; pass < 2; pass++) begin
			for (int i = 0; i < io_pkg::BANK_DEPTH; i++) begin
				rnd = $random(seed);
				write64(1, i[3:0], rnd[7:0], rand_word());
			end
		end
		for (int i = 0; i < io_pkg::BANK_DEPTH; i++) begin
			k = i[3:0];
			read_check("reg64 readback", 1, 8'hFF,
				io_addr(io_pkg::DEV_REG64, off64(k)), mem64[k]);
		end

		// 32-bit bank, even words through the lower nibble and odd words the upper
		for (int i = 0; i < io_pkg::BANK_DEPTH; i++) begin
			k = i[3:0];
			rnd = $random(seed);
			nib = rnd[3:0];
			if (nib == 4'h0) begin
				nib = 4'h1;
			end
			write32(1, k, k[0] ? {nib, 4'h0} : {4'h0, nib}, rand_word());
		end
		for (int i = 0; i < io_pkg::BANK_DEPTH; i++) begin
			k = i[3:0];
			read_check("reg32 readback", 1, k[0] ? 8'hF0 : 8'h0F,
				io_addr(io_pkg::DEV_REG32, off32(k)), {mem32[k], mem32[k]});
		end

		// unclaimed device reads zero and swallows writes
		read_check("hole read", 1, 8'hFF, io_addr(HOLE_DEV, 12'h010), '0);
		bus_cycle(1, 1'b1, 8'hFF, io_addr(HOLE_DEV, 12'h010), rand_word(), 1'b1, q1, t1);
		read_check("hole read after write", 1, 8'hFF, io_addr(HOLE_DEV, 12'h010), '0);
		verify_banks("banks after hole write");

		// outside the window nothing answers, and the bridge still works afterwards
		bus_cycle(1, 1'b0, 8'hFF, 32'hABC0_0018, '0, 1'b0, q1, t1);
		write64(1, 4'd3, 8'hFF, rand_word());
		read_check("access after miss", 1, 8'hFF,
			io_addr(io_pkg::DEV_REG64, off64(4'd3)), mem64[3]);

		// both ports read in the same cycle, port 1 is served first
		fork
			bus_cycle(1, 1'b0, 8'hFF, io_addr(io_pkg::DEV_REG64, off64(4'd5)),
				'0, 1'b1, q1, t1);
			bus_cycle(2, 1'b0, 8'h0F, io_addr(io_pkg::DEV_REG32, off32(4'd6)),
				'0, 1'b1, q2, t2);
		join
		compare_data("contention read port 1", mem64[5], q1);
		compare_data("contention read port 2", {mem32[6], mem32[6]}, q2);
		checks++;
		assert (t1 < t2) else begin
			bus_errors++;
			$display("ERROR: port 2 was acknowledged before port 1 in a read contention");
		end

		// both ports write in the same cycle, then each reads the other's word
		d1 = rand_word();
		d2 = rand_word();
		fork
			write64(1, 4'd9, 8'hFF, d1);
			write64(2, 4'd10, 8'h3C, d2);
		join
		read_check("contention write port 1", 2, 8'hFF,
			io_addr(io_pkg::DEV_REG64, off64(4'd9)), mem64[9]);
		read_check("contention write port 2", 1, 8'hFF,
			io_addr(io_pkg::DEV_REG64, off64(4'd10)), mem64[10]);

		// protocol rule failures from the bound checker
		assert_errors = i_io_subsystem.i_io_bridge.i_io_bridge_chk.fail_cnt;

		$display("checks %0d, data errors %0d, bus errors %0d, assertion errors %0d",
			checks, data_errors, bus_errors, assert_errors);
		if (data_errors == 0 && bus_errors == 0 && assert_errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

//--- files.f
source/io_pkg.sv
source/io_bridge.sv
source/io_decoder.sv
source/io_reg_bank.sv
source/io_subsystem.sv
sim/tb_clock.sv
sim/io_bridge_chk.sv
sim/io_subsystem_tb.sv

//--- Makefile
# Verilator build and run for the I/O bridge subsystem

TOP := io_subsystem_tb

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): files.f source/*.sv sim/*.sv
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module $(TOP) -f files.f

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > run.log 2>&1; cat run.log
	@if grep -q "Test failed" run.log; then echo "simulation reported a failure"; exit 1; fi
	@if ! grep -q "Test passed" run.log; then echo "simulation ended without a result"; exit 1; fi

lint:
	verilator --lint-only --timing --assert --timescale 1ns/1ps \
		--top-module $(TOP) -f files.f

clean:
	rm -rf obj_dir run.log
